// File: include/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction and datapath widths
`define INSTR_W 16
`define WORD_W 32

// register file addressing
`define REG_ADDR_W 4

// only the low registers r0-r7 can appear in a STM/LDM list
`define REG_LIST_W 8

// wide enough to count a full list of eight
`define COUNT_W 4

// bytes per transferred register
`define XFER_STRIDE 4

`endif

// File: logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // major opcode classes on instr[15:10] with ? marking don't-care bits
    typedef enum logic [5:0] {
        SHIFT_IMM       = 6'b00_????,
        DATA_PROC       = 6'b01_0000,
        LOAD_STORE_REG  = 6'b01_01??,
        LOAD_STORE_IMM  = 6'b01_10??,
        LOAD_STORE_BYTE = 6'b01_11??,
        LOAD_STORE_HW   = 6'b10_00??,
        LOAD_STORE_SP_R = 6'b10_01??,
        STORE_MULT_REG  = 6'b11_000?,
        LOAD_MULT_REG   = 6'b11_001?
    } opcode_e;

    // shift/add/sub/mov/cmp sub-codes on instr[13:9]
    typedef enum logic [4:0] {
        SH_LSL_IMM = 5'b000??,
        SH_LSR_IMM = 5'b001??,
        SH_ASR_IMM = 5'b010??,
        SH_ADD_REG = 5'b01100,
        SH_SUB_REG = 5'b01101,
        SH_ADD_3   = 5'b01110,
        SH_SUB_3   = 5'b01111,
        SH_MOV_8   = 5'b100??,
        SH_CMP_8   = 5'b101??,
        SH_ADD_8   = 5'b110??,
        SH_SUB_8   = 5'b111??
    } shift_code_e;

    // data-processing sub-codes on instr[9:6]
    typedef enum logic [3:0] {
        DP_AND  = 4'b0000,
        DP_XOR  = 4'b0001,
        DP_LSL  = 4'b0010,
        DP_LSR  = 4'b0011,
        DP_ASR  = 4'b0100,
        DP_ADC  = 4'b0101,
        DP_SBC  = 4'b0110,
        DP_ROR  = 4'b0111,
        DP_TST  = 4'b1000,
        DP_RSB  = 4'b1001,
        DP_CMP  = 4'b1010,
        DP_CMN  = 4'b1011,
        DP_OR   = 4'b1100,
        DP_MULT = 4'b1101,
        DP_BIC  = 4'b1110,
        DP_NOT  = 4'b1111
    } dp_code_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOT, BIT_CLEAR, MULT, LSL, LSR, ASR, ROR
    } alu_op_e;

    typedef enum logic [1:0] {
        FROM_REG, FROM_IMM, FROM_ZERO, FROM_ACCUMULATOR
    } alu_src_e;

    typedef enum logic {FROM_ALU, FROM_MEM} wb_src_e;

    typedef enum logic {ADDR_FROM_INSTRUCTION, ADDR_FROM_CTRL_UNIT} addr_src_e;

endpackage

`default_nettype wire

// File: logic/data_op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module data_op_decoder (
    input  wire logic [`INSTR_W-1:0] instr_i,
    output logic                     update_flag_o,
    output logic                     mem_write_o,
    output logic                     reg_write_o,
    output ctrl_pkg::wb_src_e        wb_src_o,
    output ctrl_pkg::alu_src_e       alu_in1_sel_o,
    output ctrl_pkg::alu_src_e       alu_in2_sel_o,
    output ctrl_pkg::alu_op_e        alu_op_o
);
    import ctrl_pkg::*;

    logic [4:0] shift_code;
    logic [3:0] dp_code;

    assign shift_code = instr_i[13:9];
    assign dp_code    = instr_i[9:6];

    always_comb begin
        update_flag_o = 1'b0;
        mem_write_o   = 1'b0;
        reg_write_o   = 1'b0;
        wb_src_o      = FROM_ALU;
        alu_in1_sel_o = FROM_REG;
        alu_in2_sel_o = FROM_REG;
        alu_op_o      = ADD;

        casez (instr_i[15:10])
            SHIFT_IMM: begin
                update_flag_o = 1'b1;
                reg_write_o   = 1'b1;
                casez (shift_code)
                    SH_LSL_IMM: begin
                        alu_op_o      = LSL;
                        alu_in2_sel_o = FROM_IMM;
                    end
                    SH_LSR_IMM: begin
                        alu_op_o      = LSR;
                        alu_in2_sel_o = FROM_IMM;
                    end
                    SH_ASR_IMM: begin
                        alu_op_o      = ASR;
                        alu_in2_sel_o = FROM_IMM;
                    end
                    SH_ADD_REG: alu_op_o = ADD;
                    SH_SUB_REG: alu_op_o = SUB;
                    SH_ADD_3, SH_ADD_8: alu_in2_sel_o = FROM_IMM;
                    SH_SUB_3, SH_SUB_8: begin
                        alu_op_o      = SUB;
                        alu_in2_sel_o = FROM_IMM;
                    end
                    // mov is 0 + imm
                    SH_MOV_8: begin
                        alu_in1_sel_o = FROM_ZERO;
                        alu_in2_sel_o = FROM_IMM;
                    end
                    SH_CMP_8: begin
                        alu_op_o      = SUB;
                        alu_in2_sel_o = FROM_IMM;
                        reg_write_o   = 1'b0;
                    end
                    default: ;
                endcase
            end
            DATA_PROC: begin
                update_flag_o = 1'b1;
                reg_write_o   = 1'b1;
                case (dp_code)
                    DP_AND:  alu_op_o = AND;
                    DP_XOR:  alu_op_o = XOR;
                    DP_LSL:  alu_op_o = LSL;
                    DP_LSR:  alu_op_o = LSR;
                    DP_ASR:  alu_op_o = ASR;
                    DP_ADC:  alu_op_o = ADD;
                    DP_SBC:  alu_op_o = SUB;
                    DP_ROR:  alu_op_o = ROR;
                    DP_OR:   alu_op_o = OR;
                    DP_MULT: alu_op_o = MULT;
                    DP_BIC:  alu_op_o = BIT_CLEAR;
                    DP_NOT:  alu_op_o = NOT;
                    // negate as 0 - rm
                    DP_RSB: begin
                        alu_op_o      = SUB;
                        alu_in1_sel_o = FROM_ZERO;
                    end
                    // tst, cmp and cmn only touch the flags
                    DP_TST: begin
                        alu_op_o    = AND;
                        reg_write_o = 1'b0;
                    end
                    DP_CMP: begin
                        alu_op_o    = SUB;
                        reg_write_o = 1'b0;
                    end
                    DP_CMN: begin
                        alu_op_o    = ADD;
                        reg_write_o = 1'b0;
                    end
                    default: ;
                endcase
            end
            // ldrsb (opB 011) is a load even with instr[11] clear
            LOAD_STORE_REG: begin
                if (instr_i[11] || instr_i[10:9] == 2'b11) begin
                    reg_write_o = 1'b1;
                    wb_src_o    = FROM_MEM;
                end else begin
                    mem_write_o = 1'b1;
                end
            end
            LOAD_STORE_IMM, LOAD_STORE_BYTE, LOAD_STORE_HW, LOAD_STORE_SP_R: begin
                alu_in2_sel_o = FROM_IMM;
                if (instr_i[11]) begin
                    reg_write_o = 1'b1;
                    wb_src_o    = FROM_MEM;
                end else begin
                    mem_write_o = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/reg_list_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module reg_list_sequencer (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic [`INSTR_W-1:0]    instr_i,
    input  wire logic                   stall_i,
    output logic                        seq_active_o,
    output logic [`REG_ADDR_W-1:0]      next_reg_o,
    output logic [`COUNT_W-1:0]         xfer_count_o,
    output logic [`COUNT_W-1:0]         list_count_o,
    output logic                        base_in_list_o
);
    import ctrl_pkg::*;

    logic [`REG_LIST_W-1:0] reg_list;
    logic [`REG_LIST_W-1:0] mask;
    logic [`REG_LIST_W-1:0] remaining;
    logic [`REG_LIST_W-1:0] pick_onehot;
    logic [`REG_ADDR_W-1:0] lowest_reg;
    logic [`REG_ADDR_W-1:0] highest_reg;
    logic [`REG_ADDR_W-1:0] pick_reg;
    logic [`REG_ADDR_W-1:0] base_reg;
    logic [`COUNT_W-1:0]    xfer_count;
    logic [`COUNT_W-1:0]    popcount;
    logic                   base_seen;
    logic                   is_ldm;

    assign reg_list  = instr_i[`REG_LIST_W-1:0];
    assign remaining = reg_list & mask;
    assign is_ldm    = (instr_i[15:10] ==? LOAD_MULT_REG);
    assign base_reg  = `REG_ADDR_W'(instr_i[10:8]);

    // lowest and highest remaining register, plus list size
    always_comb begin
        lowest_reg  = '0;
        highest_reg = '0;
        popcount    = '0;
        for (int i = `REG_LIST_W - 1; i >= 0; i--) begin
            if (remaining[i])
                lowest_reg = `REG_ADDR_W'(i);
        end
        for (int i = 0; i < `REG_LIST_W; i++) begin
            if (remaining[i])
                highest_reg = `REG_ADDR_W'(i);
            if (reg_list[i])
                popcount = popcount + 1'b1;
        end
    end

    // ldm walks downwards, stm upwards
    assign pick_reg    = is_ldm ? highest_reg : lowest_reg;
    assign pick_onehot = `REG_LIST_W'(1) << pick_reg;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !stall_i) begin
            mask       <= '1;
            xfer_count <= '0;
            base_seen  <= 1'b0;
        end else begin
            mask       <= mask & ~pick_onehot;
            xfer_count <= xfer_count + 1'b1;
            if (pick_reg == base_reg)
                base_seen <= 1'b1;
        end
    end

    assign seq_active_o   = |remaining;
    assign next_reg_o     = pick_reg;
    assign xfer_count_o   = xfer_count;
    assign list_count_o   = popcount;
    assign base_in_list_o = base_seen;

endmodule

`default_nettype wire

// File: logic/block_transfer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module block_transfer_ctrl (
    input  wire logic [`INSTR_W-1:0]    instr_i,
    input  wire logic                   update_flag_i,
    input  wire logic                   mem_write_i,
    input  wire logic                   reg_write_i,
    input  wire ctrl_pkg::wb_src_e      wb_src_i,
    input  wire ctrl_pkg::alu_src_e     alu_in1_sel_i,
    input  wire ctrl_pkg::alu_src_e     alu_in2_sel_i,
    input  wire ctrl_pkg::alu_op_e      alu_op_i,
    input  wire logic                   seq_active_i,
    input  wire logic [`REG_ADDR_W-1:0] next_reg_i,
    input  wire logic [`COUNT_W-1:0]    xfer_count_i,
    input  wire logic [`COUNT_W-1:0]    list_count_i,
    input  wire logic                   base_in_list_i,
    output logic                        update_flag_o,
    output logic                        mem_write_o,
    output logic                        mem_read_o,
    output logic                        reg_write_o,
    output ctrl_pkg::wb_src_e           wb_src_o,
    output ctrl_pkg::alu_src_e          alu_in1_sel_o,
    output ctrl_pkg::alu_src_e          alu_in2_sel_o,
    output ctrl_pkg::alu_op_e           alu_op_o,
    output logic                        stall_o,
    output logic [`WORD_W-1:0]          imm_o,
    output logic [`REG_ADDR_W-1:0]      reg_addr_o,
    output ctrl_pkg::addr_src_e         reg_addr2_src_o,
    output ctrl_pkg::addr_src_e         reg_dest_src_o
);
    import ctrl_pkg::*;

    logic                   is_stm;
    logic                   is_ldm;
    logic [`REG_ADDR_W-1:0] base_reg;
    logic [`COUNT_W-1:0]    steps_left;
    logic [`WORD_W-1:0]     up_offset;
    logic [`WORD_W-1:0]     down_offset;
    logic [`WORD_W-1:0]     total_offset;

    assign is_stm   = (instr_i[15:10] ==? STORE_MULT_REG);
    assign is_ldm   = (instr_i[15:10] ==? LOAD_MULT_REG);
    assign base_reg = `REG_ADDR_W'(instr_i[10:8]);

    // offsets from the base for step k of N
    assign steps_left   = list_count_i - xfer_count_i - 1'b1;
    assign up_offset    = `WORD_W'(xfer_count_i) * `XFER_STRIDE;
    assign down_offset  = `WORD_W'(steps_left) * `XFER_STRIDE;
    assign total_offset = `WORD_W'(list_count_i) * `XFER_STRIDE;

    always_comb begin
        update_flag_o   = update_flag_i;
        mem_write_o     = mem_write_i;
        mem_read_o      = 1'b0;
        reg_write_o     = reg_write_i;
        wb_src_o        = wb_src_i;
        alu_in1_sel_o   = alu_in1_sel_i;
        alu_in2_sel_o   = alu_in2_sel_i;
        alu_op_o        = alu_op_i;
        stall_o         = 1'b0;
        imm_o           = '0;
        reg_addr_o      = '0;
        reg_addr2_src_o = ADDR_FROM_INSTRUCTION;
        reg_dest_src_o  = ADDR_FROM_INSTRUCTION;

        if (is_stm) begin
            stall_o       = seq_active_i;
            alu_in2_sel_o = FROM_ACCUMULATOR;
            if (seq_active_i) begin
                mem_write_o     = 1'b1;
                reg_addr2_src_o = ADDR_FROM_CTRL_UNIT;
                reg_addr_o      = next_reg_i;
                imm_o           = up_offset;
            end else begin
                reg_write_o    = 1'b1;
                reg_dest_src_o = ADDR_FROM_CTRL_UNIT;
                reg_addr_o     = base_reg;
                imm_o          = total_offset;
            end
        end else if (is_ldm) begin
            stall_o        = seq_active_i;
            alu_in2_sel_o  = FROM_ACCUMULATOR;
            reg_dest_src_o = ADDR_FROM_CTRL_UNIT;
            if (seq_active_i) begin
                reg_write_o = 1'b1;
                wb_src_o    = FROM_MEM;
                reg_addr_o  = next_reg_i;
                imm_o       = down_offset;
            end else begin
                // a loaded base keeps the loaded value
                reg_write_o = !base_in_list_i;
                reg_addr_o  = base_reg;
                imm_o       = total_offset;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ctrl_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module ctrl_unit (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic [`INSTR_W-1:0]    instr_i,
    output logic                        update_flag_o,
    output logic                        mem_write_o,
    output logic                        mem_read_o,
    output logic                        reg_write_o,
    output ctrl_pkg::wb_src_e           wb_src_o,
    output ctrl_pkg::alu_src_e          alu_in1_sel_o,
    output ctrl_pkg::alu_src_e          alu_in2_sel_o,
    output ctrl_pkg::alu_op_e           alu_op_o,
    output logic                        stall_o,
    output logic [`WORD_W-1:0]          imm_o,
    output logic [`REG_ADDR_W-1:0]      reg_addr_o,
    output ctrl_pkg::addr_src_e         reg_addr2_src_o,
    output ctrl_pkg::addr_src_e         reg_dest_src_o
);
    import ctrl_pkg::*;

    // single-cycle decode
    logic     dec_update_flag;
    logic     dec_mem_write;
    logic     dec_reg_write;
    wb_src_e  dec_wb_src;
    alu_src_e dec_alu_in1_sel;
    alu_src_e dec_alu_in2_sel;
    alu_op_e  dec_alu_op;

    // multi-register sequencing
    logic                   seq_active;
    logic [`REG_ADDR_W-1:0] next_reg;
    logic [`COUNT_W-1:0]    xfer_count;
    logic [`COUNT_W-1:0]    list_count;
    logic                   base_in_list;

    data_op_decoder u_decoder (
        .instr_i       (instr_i),
        .update_flag_o (dec_update_flag),
        .mem_write_o   (dec_mem_write),
        .reg_write_o   (dec_reg_write),
        .wb_src_o      (dec_wb_src),
        .alu_in1_sel_o (dec_alu_in1_sel),
        .alu_in2_sel_o (dec_alu_in2_sel),
        .alu_op_o      (dec_alu_op)
    );

    reg_list_sequencer u_sequencer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_i        (instr_i),
        .stall_i        (stall_o),
        .seq_active_o   (seq_active),
        .next_reg_o     (next_reg),
        .xfer_count_o   (xfer_count),
        .list_count_o   (list_count),
        .base_in_list_o (base_in_list)
    );

    block_transfer_ctrl u_block_ctrl (
        .instr_i         (instr_i),
        .update_flag_i   (dec_update_flag),
        .mem_write_i     (dec_mem_write),
        .reg_write_i     (dec_reg_write),
        .wb_src_i        (dec_wb_src),
        .alu_in1_sel_i   (dec_alu_in1_sel),
        .alu_in2_sel_i   (dec_alu_in2_sel),
        .alu_op_i        (dec_alu_op),
        .seq_active_i    (seq_active),
        .next_reg_i      (next_reg),
        .xfer_count_i    (xfer_count),
        .list_count_i    (list_count),
        .base_in_list_i  (base_in_list),
        .update_flag_o   (update_flag_o),
        .mem_write_o     (mem_write_o),
        .mem_read_o      (mem_read_o),
        .reg_write_o     (reg_write_o),
        .wb_src_o        (wb_src_o),
        .alu_in1_sel_o   (alu_in1_sel_o),
        .alu_in2_sel_o   (alu_in2_sel_o),
        .alu_op_o        (alu_op_o),
        .stall_o         (stall_o),
        .imm_o           (imm_o),
        .reg_addr_o      (reg_addr_o),
        .reg_addr2_src_o (reg_addr2_src_o),
        .reg_dest_src_o  (reg_dest_src_o)
    );

endmodule

`default_nettype wire

// File: tb/ctrl_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module ctrl_unit_asserts (
    input wire logic                clk_i,
    input wire logic                rst_n_i,
    input wire logic [`INSTR_W-1:0] instr_i,
    input wire logic                stall_i,
    input wire logic                mem_read_i
);

    // sequencer leaves reset idle
    stall_low_after_reset: assert property (
        @(posedge clk_i) $rose(rst_n_i) |-> !stall_i
    ) else $error("stall_o is high in the first cycle after reset");

    // fetch side holds the instruction through a transfer
    instr_held_during_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) stall_i |=> $stable(instr_i)
    ) else $error("instr_i changed while stall_o was high");

    // no kept instruction reads memory
    mem_read_never_set: assert property (
        @(posedge clk_i) !mem_read_i
    ) else $error("mem_read_o went high");

endmodule

bind ctrl_unit ctrl_unit_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .instr_i    (instr_i),
    .stall_i    (stall_o),
    .mem_read_i (mem_read_o)
);

`default_nettype wire

// File: tb/ctrl_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module ctrl_unit_tb;
    import ctrl_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int STALL_TIMEOUT = 20;

    typedef struct packed {
        logic                   update_flag;
        logic                   mem_write;
        logic                   mem_read;
        logic                   reg_write;
        wb_src_e                wb_src;
        alu_src_e               alu_in1_sel;
        alu_src_e               alu_in2_sel;
        alu_op_e                alu_op;
        logic                   stall;
        logic [`WORD_W-1:0]     imm;
        logic [`REG_ADDR_W-1:0] reg_addr;
        addr_src_e              reg_addr2_src;
        addr_src_e              reg_dest_src;
    } ctrl_t;

    logic                   clk_i;
    logic                   rst_n_i;
    logic [`INSTR_W-1:0]    instr_i;
    logic                   update_flag_o;
    logic                   mem_write_o;
    logic                   mem_read_o;
    logic                   reg_write_o;
    wb_src_e                wb_src_o;
    alu_src_e               alu_in1_sel_o;
    alu_src_e               alu_in2_sel_o;
    alu_op_e                alu_op_o;
    logic                   stall_o;
    logic [`WORD_W-1:0]     imm_o;
    logic [`REG_ADDR_W-1:0] reg_addr_o;
    addr_src_e              reg_addr2_src_o;
    addr_src_e              reg_dest_src_o;

    // instruction and step the reference is evaluated for
    logic [`INSTR_W-1:0]    cur_instr;
    int                     cur_step;
    logic                   check_en;
    int                     check_count;
    int                     error_count;
    int                     timeout_count;

    ctrl_unit DUT (.*);

    always #20 clk_i = ~clk_i;

    // expected controls at transfer step k, where k = N is the base write-back cycle
    function automatic ctrl_t expected_ctrl(input logic [`INSTR_W-1:0] instr, input int step);
        ctrl_t      e;
        logic [7:0] list;
        int         n;
        int         seen;
        int         idx;
        int         i;
        e.update_flag   = 1'b0;
        e.mem_write     = 1'b0;
        e.mem_read      = 1'b0;
        e.reg_write     = 1'b0;
        e.wb_src        = FROM_ALU;
        e.alu_in1_sel   = FROM_REG;
        e.alu_in2_sel   = FROM_REG;
        e.alu_op        = ADD;
        e.stall         = 1'b0;
        e.imm           = '0;
        e.reg_addr      = '0;
        e.reg_addr2_src = ADDR_FROM_INSTRUCTION;
        e.reg_dest_src  = ADDR_FROM_INSTRUCTION;
        list = instr[7:0];
        n    = 0;
        for (i = 0; i < 8; i++)
            n += list[i];

        if (instr[15:14] == 2'b00) begin
            e.update_flag = 1'b1;
            case (instr[13:11])
                3'b000:         e.alu_op = LSL;
                3'b001:         e.alu_op = LSR;
                3'b010:         e.alu_op = ASR;
                3'b011:         e.alu_op = instr[9] ? SUB : ADD;
                3'b101, 3'b111: e.alu_op = SUB;
                default:        e.alu_op = ADD;
            endcase
            // only add/sub with a register operand reads rm
            e.alu_in2_sel = (instr[13:11] == 3'b011 && !instr[10]) ? FROM_REG : FROM_IMM;
            e.alu_in1_sel = (instr[13:11] == 3'b100) ? FROM_ZERO : FROM_REG;
            e.reg_write   = (instr[13:11] != 3'b101);
        end else if (instr[15:10] == 6'b010000) begin
            e.update_flag = 1'b1;
            case (instr[9:6])
                4'd0, 4'd8:        e.alu_op = AND;
                4'd1:              e.alu_op = XOR;
                4'd2:              e.alu_op = LSL;
                4'd3:              e.alu_op = LSR;
                4'd4:              e.alu_op = ASR;
                4'd6, 4'd9, 4'd10: e.alu_op = SUB;
                4'd7:              e.alu_op = ROR;
                4'd12:             e.alu_op = OR;
                4'd13:             e.alu_op = MULT;
                4'd14:             e.alu_op = BIT_CLEAR;
                4'd15:             e.alu_op = NOT;
                default:           e.alu_op = ADD;
            endcase
            // tst, cmp, cmn write no register
            e.reg_write   = !(instr[9:6] == 4'd8 || instr[9:6] == 4'd10 || instr[9:6] == 4'd11);
            e.alu_in1_sel = (instr[9:6] == 4'd9) ? FROM_ZERO : FROM_REG;
        end else if (instr[15:12] >= 4'b0101 && instr[15:12] <= 4'b1001) begin
            if (instr[15:12] != 4'b0101)
                e.alu_in2_sel = FROM_IMM;
            if (instr[11] || (instr[15:12] == 4'b0101 && instr[10:9] == 2'b11)) begin
                e.reg_write = 1'b1;
                e.wb_src    = FROM_MEM;
            end else begin
                e.mem_write = 1'b1;
            end
        end else if (instr[15:12] == 4'b1100) begin
            e.alu_in2_sel = FROM_ACCUMULATOR;
            if (instr[11])
                e.reg_dest_src = ADDR_FROM_CTRL_UNIT;
            if (step < n) begin
                // stm counts listed registers up from r0 and ldm down from r7
                seen = 0;
                for (i = 0; i < 8; i++) begin
                    idx = instr[11] ? 7 - i : i;
                    if (list[idx]) begin
                        if (seen == step)
                            e.reg_addr = `REG_ADDR_W'(idx);
                        seen++;
                    end
                end
                e.stall = 1'b1;
                if (instr[11]) begin
                    e.reg_write = 1'b1;
                    e.wb_src    = FROM_MEM;
                    e.imm       = `WORD_W'(`XFER_STRIDE * (n - 1 - step));
                end else begin
                    e.mem_write     = 1'b1;
                    e.reg_addr2_src = ADDR_FROM_CTRL_UNIT;
                    e.imm           = `WORD_W'(`XFER_STRIDE * step);
                end
            end else begin
                e.reg_addr = {1'b0, instr[10:8]};
                e.imm      = `WORD_W'(`XFER_STRIDE * n);
                if (instr[11]) begin
                    e.reg_write = !list[instr[10:8]];
                end else begin
                    e.reg_write    = 1'b1;
                    e.reg_dest_src = ADDR_FROM_CTRL_UNIT;
                end
            end
        end
        return e;
    endfunction

    task automatic check_value(input string what, input logic [`WORD_W-1:0] actual,
                               input logic [`WORD_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t: %s is %0h, expected %0h (instr %h, step %0d)",
                     $time, what, actual, expected, cur_instr, cur_step);
        end
    endtask

    // all outputs follow instr_i and the sequencer state within the cycle
    always @(negedge clk_i) begin : compare_outputs
        ctrl_t want;
        if (check_en) begin
            want = expected_ctrl(cur_instr, cur_step);
            check_value("update_flag_o", update_flag_o, want.update_flag);
            check_value("mem_write_o", mem_write_o, want.mem_write);
            check_value("mem_read_o", mem_read_o, want.mem_read);
            check_value("reg_write_o", reg_write_o, want.reg_write);
            check_value("wb_src_o", wb_src_o, want.wb_src);
            check_value("alu_in1_sel_o", alu_in1_sel_o, want.alu_in1_sel);
            check_value("alu_in2_sel_o", alu_in2_sel_o, want.alu_in2_sel);
            check_value("alu_op_o", alu_op_o, want.alu_op);
            check_value("stall_o", stall_o, want.stall);
            check_value("imm_o", imm_o, want.imm);
            check_value("reg_addr_o", reg_addr_o, want.reg_addr);
            check_value("reg_addr2_src_o", reg_addr2_src_o, want.reg_addr2_src);
            check_value("reg_dest_src_o", reg_dest_src_o, want.reg_dest_src);
        end
    end

    // present one instruction and hold it until stall_o drops
    task automatic run_instr(input logic [`INSTR_W-1:0] instr);
        ctrl_t probe;
        int    expected_stalls;
        int    stalled;
        expected_stalls = 0;
        probe = expected_ctrl(instr, 0);
        while (probe.stall) begin
            expected_stalls++;
            probe = expected_ctrl(instr, expected_stalls);
        end
        stalled = 0;
        @(posedge clk_i);
        instr_i   <= instr;
        cur_instr <= instr;
        cur_step  <= 0;
        @(negedge clk_i);
        while (stall_o && stalled < STALL_TIMEOUT) begin
            @(posedge clk_i);
            cur_step <= cur_step + 1;
            @(negedge clk_i);
            stalled++;
        end
        if (stall_o) begin
            timeout_count++;
            $display("timeout: stall_o still high after %0d cycles for instruction %h",
                     stalled, instr);
        end else begin
            check_value("stall cycles", stalled, expected_stalls);
        end
    endtask

    function automatic logic [`INSTR_W-1:0] random_alu_instr();
        logic [15:0] bits;
        bits = 16'($urandom);
        if ($urandom % 2)
            return {2'b00, bits[13:0]};
        return {6'b010000, bits[9:0]};
    endfunction

    // register, immediate, byte, halfword and sp-relative groups
    function automatic logic [`INSTR_W-1:0] random_mem_instr();
        logic [3:0] group;
        group = 4'b0101 + 4'($urandom % 5);
        return {group, 12'($urandom)};
    endfunction

    function automatic logic [`INSTR_W-1:0] random_block_instr(input logic is_load);
        logic [7:0] list;
        logic [2:0] base;
        list = 8'($urandom);
        base = 3'($urandom);
        if (list == 8'h00)
            list = 8'h01 << base;
        return {4'b1100, is_load, base, list};
    endfunction

    initial begin
        void'($urandom(51));
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_i       = 16'h430A;
        cur_instr     = 16'h430A;
        cur_step      = 0;
        check_en      = 1'b0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i  <= 1'b1;
        check_en <= 1'b1;

        // orr then cmp straight out of reset
        run_instr(16'h430A);
        run_instr(16'h4281);
        repeat (60) run_instr(random_alu_instr());
        repeat (40) run_instr(random_mem_instr());
        repeat (20) run_instr(random_block_instr(1'b0));
        repeat (20) run_instr(random_block_instr(1'b1));
        run_instr({5'b11000, 3'd2, 8'h00});
        run_instr({5'b11001, 3'd5, 8'h00});
        run_instr({5'b11001, 3'd3, 8'hFF});
        run_instr({5'b11001, 3'd3, 8'hF7});
        run_instr(16'h430A);

        @(posedge clk_i);
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
logic/ctrl_pkg.sv
logic/data_op_decoder.sv
logic/reg_list_sequencer.sv
logic/block_transfer_ctrl.sv
logic/ctrl_unit.sv
tb/ctrl_unit_asserts.sv
tb/ctrl_unit_tb.sv

// File: Bender.yml
package:
  name: ctrl_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/ctrl_pkg.sv
      - logic/data_op_decoder.sv
      - logic/reg_list_sequencer.sv
      - logic/block_transfer_ctrl.sv
      - logic/ctrl_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/ctrl_unit_asserts.sv
      - tb/ctrl_unit_tb.sv
